/* common/mul_pkg.sv */
package mul_pkg;

	// ************************************************************************
	// operand and product widths
	// ************************************************************************
	localparam int XLEN   = 64;
	localparam int WORD_W = 32;
	// operands carry two extra bits so every sign mode becomes a signed multiply
	localparam int EXT_W  = XLEN + 2;
	localparam int PROD_W = 2 * EXT_W;

	typedef logic [XLEN-1:0]   xlen_t;
	typedef logic [EXT_W-1:0]  ext_t;
	typedef logic [PROD_W-1:0] prod_t;

	// bit 0: multiplicand signed, bit 1: multiplier signed
	typedef enum logic [1:0] {
		MUL_UU = 2'b00,
		MUL_SU = 2'b01,
		MUL_SS = 2'b11
	} mul_sign_e;

	// request queue, depth is also the producer's starting credit count
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

	typedef logic [QPTR_W-1:0] qptr_t;
	typedef logic [QCNT_W-1:0] qcnt_t;

	// radix-4 steps, two multiplier bits each: 66/2 full, 34/2 word
	localparam int BOOTH_STEPS   = EXT_W / 2;
	localparam int BOOTH_STEPS_W = (WORD_W + 2) / 2;

	typedef logic [$clog2(BOOTH_STEPS + 1)-1:0] step_cnt_t;

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		DONE
	} booth_state_e;

endpackage

/* common/regfile_pkg.sv */
package regfile_pkg;

	// ************************************************************************
	// general purpose register file
	// ************************************************************************
	localparam int NUM_REGS  = 32;
	localparam int REG_IDX_W = $clog2(NUM_REGS);

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// x0, hardwired to zero
	localparam reg_idx_t REG_ZERO = '0;

endpackage

/* multiplier/mul_request_queue.sv */
module mul_request_queue import mul_pkg::*, regfile_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      flush,
	input  logic      in_valid,
	input  xlen_t     in_mulcand,
	input  xlen_t     in_muler,
	input  mul_sign_e in_sign,
	input  logic      in_word,
	input  logic      in_high,
	input  reg_idx_t  in_rd,
	input  logic      out_ready,
	output logic      out_valid,
	output xlen_t     out_mulcand,
	output xlen_t     out_muler,
	output mul_sign_e out_sign,
	output logic      out_word,
	output logic      out_high,
	output reg_idx_t  out_rd,
	output logic      credit_return
);

	// entry storage
	xlen_t     mulcand_mem [QUEUE_DEPTH];
	xlen_t     muler_mem   [QUEUE_DEPTH];
	mul_sign_e sign_mem    [QUEUE_DEPTH];
	logic      word_mem    [QUEUE_DEPTH];
	logic      high_mem    [QUEUE_DEPTH];
	reg_idx_t  rd_mem      [QUEUE_DEPTH];

	qptr_t wptr;
	qptr_t rptr;
	qcnt_t count;
	logic  push;
	logic  pop;

	function automatic qptr_t next_ptr(input qptr_t p);
		next_ptr = (p == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// no full check, the producer only sends with a credit in hand
	assign push = in_valid & ~flush;
	assign pop  = out_valid & out_ready & ~flush;

	// ************************************************************************
	// pointers and occupancy
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wptr <= next_ptr(wptr);
			if (pop)
				rptr <= next_ptr(rptr);
			count <= count + qcnt_t'(push) - qcnt_t'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mulcand_mem[wptr] <= in_mulcand;
			muler_mem[wptr] <= in_muler;
			sign_mem[wptr] <= in_sign;
			word_mem[wptr] <= in_word;
			high_mem[wptr] <= in_high;
			rd_mem[wptr] <= in_rd;
		end
	end

	// head of queue
	assign out_valid   = (count != '0);
	assign out_mulcand = mulcand_mem[rptr];
	assign out_muler   = muler_mem[rptr];
	assign out_sign    = sign_mem[rptr];
	assign out_word    = word_mem[rptr];
	assign out_high    = high_mem[rptr];
	assign out_rd      = rd_mem[rptr];

	// one credit back per popped entry
	assign credit_return = pop;

endmodule

/* multiplier/booth_multiplier.sv */
module booth_multiplier import mul_pkg::*, regfile_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      flush,
	input  logic      start_valid,
	output logic      start_ready,
	input  xlen_t     mulcand,
	input  xlen_t     muler,
	input  mul_sign_e sign,
	input  logic      word,
	input  logic      high,
	input  reg_idx_t  rd_in,
	output logic      done,
	output reg_idx_t  rd_out,
	output xlen_t     result
);

	booth_state_e state;
	booth_state_e state_next;
	step_cnt_t    cnt;

	// datapath registers
	prod_t          mcand_q;
	logic [EXT_W:0] mr_q;
	prod_t          acc_q;
	logic           word_q;
	logic           high_q;
	reg_idx_t       rd_q;

	ext_t  cand_ext;
	ext_t  mul_ext;
	prod_t pp;

	// widen one operand to 66 bits, word mode looks at the low 32 only
	function automatic ext_t extend(input xlen_t v, input logic sgn, input logic w);
		logic msb;
		msb = sgn & (w ? v[WORD_W-1] : v[XLEN-1]);
		if (w)
			extend = {{(EXT_W-WORD_W){msb}}, v[WORD_W-1:0]};
		else
			extend = {{(EXT_W-XLEN){msb}}, v};
	endfunction

	// multiplicand signed unless UU, multiplier signed only for SS
	assign cand_ext = extend(mulcand, sign != MUL_UU, word);
	assign mul_ext  = extend(muler, sign == MUL_SS, word);

	// ************************************************************************
	// booth recoding of the low three multiplier bits
	// ************************************************************************
	always_comb begin
		case (mr_q[2:0])
			3'b001, 3'b010: pp = mcand_q;
			3'b011:         pp = mcand_q << 1;
			3'b100:         pp = ~(mcand_q << 1) + 1'b1;
			3'b101, 3'b110: pp = ~mcand_q + 1'b1;
			default:        pp = '0;
		endcase
	end

	// ************************************************************************
	// control FSM
	// ************************************************************************
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (start_valid)
					state_next = BUSY;
			end
			BUSY: begin
				// last step retires this cycle
				if (cnt == step_cnt_t'(1))
					state_next = DONE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			state <= state_next;
			if (state == IDLE)
				cnt <= word ? step_cnt_t'(BOOTH_STEPS_W) : step_cnt_t'(BOOTH_STEPS);
			else if (state == BUSY)
				cnt <= cnt - 1'b1;
		end
	end

	// ************************************************************************
	// shift and add datapath
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (state == IDLE && start_valid) begin
			// sign extend the multiplicand across the full partial product
			mcand_q <= {{(PROD_W-EXT_W){cand_ext[EXT_W-1]}}, cand_ext};
			// implicit zero below bit 0 for the first booth group
			mr_q <= {mul_ext, 1'b0};
			acc_q <= '0;
			word_q <= word;
			high_q <= high;
			rd_q <= rd_in;
		end else if (state == BUSY) begin
			acc_q <= acc_q + pp;
			mcand_q <= mcand_q << 2;
			mr_q <= {{2{mr_q[EXT_W]}}, mr_q[EXT_W:2]};
		end
	end

	// result select
	always_comb begin
		if (word_q)
			result = {{(XLEN-WORD_W){acc_q[WORD_W-1]}}, acc_q[WORD_W-1:0]};
		else if (high_q)
			result = acc_q[2*XLEN-1:XLEN];
		else
			result = acc_q[XLEN-1:0];
	end

	assign start_ready = (state == IDLE);
	// a flush in the done cycle kills the write-back too
	assign done   = (state == DONE) & ~flush;
	assign rd_out = rd_q;

endmodule

/* source/register_file.sv */
module register_file import mul_pkg::*, regfile_pkg::*; (
	input  logic     clk,
	input  logic     wen,
	input  reg_idx_t waddr,
	input  xlen_t    wdata,
	input  reg_idx_t raddr,
	output xlen_t    rdata
);

	// ************************************************************************
	// gpr storage
	// ************************************************************************
	xlen_t regs [NUM_REGS];

	// x0 never written
	always_ff @(posedge clk) begin
		if (wen && waddr != REG_ZERO)
			regs[waddr] <= wdata;
	end

	// async read, x0 forced to zero
	always_comb begin
		if (raddr == REG_ZERO)
			rdata = '0;
		else
			rdata = regs[raddr];
	end

endmodule

/* source/npc_mul_unit.sv */
module npc_mul_unit import mul_pkg::*, regfile_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      flush,
	input  logic      req_valid,
	input  xlen_t     req_mulcand,
	input  xlen_t     req_muler,
	input  mul_sign_e req_sign,
	input  logic      req_word,
	input  logic      req_high,
	input  reg_idx_t  req_rd,
	output logic      credit_return,
	output logic      wb_valid,
	output reg_idx_t  wb_rd,
	output xlen_t     wb_data,
	input  reg_idx_t  rf_raddr,
	output xlen_t     rf_rdata
);

	// queue head towards the multiplier
	logic      q_valid;
	logic      q_ready;
	xlen_t     q_mulcand;
	xlen_t     q_muler;
	mul_sign_e q_sign;
	logic      q_word;
	logic      q_high;
	reg_idx_t  q_rd;

	// ************************************************************************
	// request queue, credit based
	// ************************************************************************
	mul_request_queue req_queue (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.in_valid     (req_valid),
		.in_mulcand   (req_mulcand),
		.in_muler     (req_muler),
		.in_sign      (req_sign),
		.in_word      (req_word),
		.in_high      (req_high),
		.in_rd        (req_rd),
		.out_ready    (q_ready),
		.out_valid    (q_valid),
		.out_mulcand  (q_mulcand),
		.out_muler    (q_muler),
		.out_sign     (q_sign),
		.out_word     (q_word),
		.out_high     (q_high),
		.out_rd       (q_rd),
		.credit_return(credit_return)
	);

	// ************************************************************************
	// booth multiplier, done drives write-back directly
	// ************************************************************************
	booth_multiplier boothmul (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.start_valid(q_valid),
		.start_ready(q_ready),
		.mulcand    (q_mulcand),
		.muler      (q_muler),
		.sign       (q_sign),
		.word       (q_word),
		.high       (q_high),
		.rd_in      (q_rd),
		.done       (wb_valid),
		.rd_out     (wb_rd),
		.result     (wb_data)
	);

	// gpr write port fed by the write-back bus
	register_file gpr (
		.clk  (clk),
		.wen  (wb_valid),
		.waddr(wb_rd),
		.wdata(wb_data),
		.raddr(rf_raddr),
		.rdata(rf_rdata)
	);

endmodule

/* sim/clock_gen.sv */
module clock_gen (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held for two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

/* sim/tb_npc_mul_unit.sv */
module tb_npc_mul_unit
	import mul_pkg::*, regfile_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic      clk;
	logic      rst;
	logic      flush;
	logic      req_valid;
	xlen_t     req_mulcand;
	xlen_t     req_muler;
	mul_sign_e req_sign;
	logic      req_word;
	logic      req_high;
	reg_idx_t  req_rd;
	logic      credit_return;
	logic      wb_valid;
	reg_idx_t  wb_rd;
	xlen_t     wb_data;
	reg_idx_t  rf_raddr;
	xlen_t     rf_rdata;

	// producer credits, scoreboard, register model
	logic [31:0] lfsr = 32'he4df_8b40;
	int          errors;
	int          timeouts;
	int          sent;
	int          returned;
	int          wb_count;
	int          sent_base;
	int          ret_base;
	bit          first_sent;
	reg_idx_t    exp_rd_q [$];
	xlen_t       exp_data_q [$];
	xlen_t       reg_model [NUM_REGS];

	localparam xlen_t ONES     = '1;
	localparam xlen_t MOST_NEG = {1'b1, 63'b0};

	clock_gen clkgen (.*);
	npc_mul_unit UUT (.*);

	// ************************************************************************
	// stimulus helpers
	// ************************************************************************
	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic xlen_t rand_bits(input int n);
		xlen_t v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[XLEN-2:0], lfsr_bit()};
		return v;
	endfunction

	// never x0 unless asked for
	function automatic reg_idx_t rand_rd();
		reg_idx_t r;
		r = reg_idx_t'(rand_bits(5));
		return (r == REG_ZERO) ? reg_idx_t'(1) : r;
	endfunction

	function automatic mul_sign_e rand_sign();
		logic [1:0] s;
		s = 2'(rand_bits(2));
		return (s == 2'd0) ? MUL_UU : (s == 2'd1) ? MUL_SU : MUL_SS;
	endfunction

	// reference result as a plain 128 bit product of the extended operands
	function automatic xlen_t expected_result(input xlen_t a, input xlen_t b,
			input mul_sign_e s, input logic w, input logic h);
		logic [127:0] ax;
		logic [127:0] bx;
		logic [127:0] p;
		logic         sa;
		logic         sb;
		sa = (s != MUL_UU);
		sb = (s == MUL_SS);
		if (w) begin
			ax = {{96{sa & a[31]}}, a[31:0]};
			bx = {{96{sb & b[31]}}, b[31:0]};
			p = ax * bx;
			return {{32{p[31]}}, p[31:0]};
		end
		ax = {{64{sa & a[63]}}, a};
		bx = {{64{sb & b[63]}}, b};
		p = ax * bx;
		return h ? p[127:64] : p[63:0];
	endfunction

	// credits held by the producer since reset or the last flush
	function automatic int credits();
		return QUEUE_DEPTH - ((sent - sent_base) - (returned - ret_base));
	endfunction

	task automatic finish_run();
		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic timed_out(input string what);
		$display("timeout at %0t: %s", $time, what);
		timeouts++;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send(input xlen_t a, input xlen_t b, input mul_sign_e s,
			input logic w, input logic h, input reg_idx_t rd);
		int n;
		n = 0;
		// hold off until a credit is back
		while (credits() == 0 && n < 4 * BOOTH_STEPS) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (credits() == 0)
			timed_out("no credit came back for a new request");
		req_valid = 1'b1;
		req_mulcand = a;
		req_muler = b;
		req_sign = s;
		req_word = w;
		req_high = h;
		req_rd = rd;
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(expected_result(a, b, s, w, h));
		sent++;
		first_sent = 1'b1;
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	// wait for every expected write-back
	task automatic drain();
		int n;
		n = 0;
		while (exp_rd_q.size() != 0 && n < (BOOTH_STEPS + 4) * (QUEUE_DEPTH + 2)) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (exp_rd_q.size() != 0)
			timed_out("write-backs still missing");
	endtask

	task automatic check_reg(input reg_idx_t r);
		xlen_t exp_val;
		exp_val = (r == REG_ZERO) ? '0 : reg_model[r];
		rf_raddr = r;
		@(negedge clk);
		assert (rf_rdata == exp_val) else begin
			errors++;
			$display("error %0t rf_rdata[x%0d] expected %h got %h",
				$time, r, exp_val, rf_rdata);
		end
		@(posedge clk);
		#1;
	endtask

	// ************************************************************************
	// write-back and credit checks at mid cycle
	// ************************************************************************
	always @(negedge clk) begin
		reg_idx_t exp_rd;
		xlen_t    exp_data;
		if (!rst) begin
			if (credit_return)
				returned++;
			// quiet until the first request
			if (!first_sent) begin
				assert (!credit_return && !wb_valid) else begin
					errors++;
					$display("error %0t credit_return/wb_valid expected 0/0 got %b/%b",
						$time, credit_return, wb_valid);
				end
			end
			if (wb_valid) begin
				wb_count++;
				assert (exp_rd_q.size() != 0) else begin
					errors++;
					$display("write-back to x%0d at %0t with no request pending",
						wb_rd, $time);
				end
				if (exp_rd_q.size() != 0) begin
					exp_rd = exp_rd_q.pop_front();
					exp_data = exp_data_q.pop_front();
					assert (wb_rd == exp_rd) else begin
						errors++;
						$display("error %0t wb_rd expected %0d got %0d",
							$time, exp_rd, wb_rd);
					end
					assert (wb_data == exp_data) else begin
						errors++;
						$display("error %0t wb_data expected %h got %h",
							$time, exp_data, wb_data);
					end
					if (exp_rd != REG_ZERO)
						reg_model[exp_rd] = exp_data;
				end
			end
		end
	end

	// ************************************************************************
	// test sequence
	// ************************************************************************
	initial begin
		mul_sign_e modes [3];
		reg_idx_t  rds [QUEUE_DEPTH];
		int        n;
		int        r0;
		int        s0;
		int        w0;
		modes = '{MUL_UU, MUL_SU, MUL_SS};
		errors = 0;
		timeouts = 0;
		sent = 0;
		returned = 0;
		wb_count = 0;
		sent_base = 0;
		ret_base = 0;
		first_sent = 1'b0;
		flush = 1'b0;
		req_valid = 1'b0;
		req_mulcand = '0;
		req_muler = '0;
		req_sign = MUL_UU;
		req_word = 1'b0;
		req_high = 1'b0;
		req_rd = '0;
		rf_raddr = '0;
		n = 0;
		while (rst !== 1'b0 && n < 10) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (rst !== 1'b0)
			timed_out("reset was never released");

		// outputs idle after reset and x0 reads zero
		idle(3);
		check_reg(REG_ZERO);

		// full mode in every sign mode and half with corners first
		foreach (modes[m]) begin
			for (int h = 0; h < 2; h++) begin
				send(ONES, ONES, modes[m], 1'b0, h[0], rand_rd());
				send(MOST_NEG, MOST_NEG, modes[m], 1'b0, h[0], rand_rd());
				send(MOST_NEG, ONES, modes[m], 1'b0, h[0], rand_rd());
				send('0, rand_bits(64), modes[m], 1'b0, h[0], rand_rd());
				repeat (4)
					send(rand_bits(64), rand_bits(64), modes[m], 1'b0, h[0], rand_rd());
				drain();
			end
		end

		// word mode where high must not matter
		send(64'hffff_ffff_8000_0000, 64'h0000_0000_ffff_ffff, MUL_SS, 1'b1, 1'b0, rand_rd());
		send(64'h1234_5678_7fff_ffff, 64'hffff_ffff_7fff_ffff, MUL_UU, 1'b1, 1'b1, rand_rd());
		repeat (10)
			send(rand_bits(64), rand_bits(64), rand_sign(), 1'b1, lfsr_bit(), rand_rd());
		drain();

		// burst on a full set of credits
		r0 = returned;
		s0 = sent;
		assert (credits() == QUEUE_DEPTH) else begin
			errors++;
			$display("error %0t credits expected %0d got %0d", $time, QUEUE_DEPTH, credits());
		end
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			rds[i] = reg_idx_t'(20 + i);
			send(rand_bits(64), rand_bits(64), rand_sign(), lfsr_bit(), lfsr_bit(), rds[i]);
		end
		drain();
		assert (returned - r0 == sent - s0) else begin
			errors++;
			$display("error %0t credit_return pulses expected %0d got %0d",
				$time, sent - s0, returned - r0);
		end
		foreach (rds[i])
			check_reg(rds[i]);

		// x0 destination
		w0 = wb_count;
		send(rand_bits(64), rand_bits(64), MUL_SS, 1'b0, 1'b0, REG_ZERO);
		drain();
		assert (wb_count - w0 == 1) else begin
			errors++;
			$display("error %0t wb_valid pulses expected 1 got %0d", $time, wb_count - w0);
		end
		check_reg(REG_ZERO);

		// flush with one in the multiplier and two queued
		r0 = returned;
		repeat (3)
			send(rand_bits(64), rand_bits(64), rand_sign(), 1'b0, lfsr_bit(), rand_rd());
		n = 0;
		while (returned == r0 && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (returned == r0)
			timed_out("first request never left the queue");
		idle(2);
		flush = 1'b1;
		exp_rd_q.delete();
		exp_data_q.delete();
		@(posedge clk);
		#1;
		flush = 1'b0;
		sent_base = sent;
		ret_base = returned;
		// stale write-backs get flagged by the checker
		idle(BOOTH_STEPS + 8);
		assert (returned == ret_base) else begin
			errors++;
			$display("error %0t credit_return pulses after flush expected 0 got %0d",
				$time, returned - ret_base);
		end
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			rds[i] = reg_idx_t'(8 + i);
			send(rand_bits(64), rand_bits(64), rand_sign(), lfsr_bit(), lfsr_bit(), rds[i]);
		end
		drain();
		foreach (rds[i])
			check_reg(rds[i]);

		finish_run();
	end

endmodule

/* npc_mul.f */
common/mul_pkg.sv
common/regfile_pkg.sv
multiplier/mul_request_queue.sv
multiplier/booth_multiplier.sv
source/register_file.sv
source/npc_mul_unit.sv
sim/clock_gen.sv
sim/tb_npc_mul_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_npc_mul_unit
FILELIST  ?= npc_mul.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  := all tests passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  build  compile the testbench and the DUT with Verilator"
	@echo "  test   build, run the simulation and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) --binary --assert --timescale $(TIMESCALE) $(VFLAGS) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
